// ==== include/fpga_ip_macros.svh ====
`ifndef FPGA_IP_MACROS_SVH
`define FPGA_IP_MACROS_SVH

// Aperture base addresses, 4 KB each
`define FPGA_REG_BASE      17'h00000
`define FLL_BASE           17'h01000
`define RESERVED_BASE      17'h05000

// Address bits that pick the aperture
`define APER_MSB           16
`define APER_LSB           12

// Fabric register byte offsets
`define ID_ADR             10'h000
`define REV_ADR            10'h004
`define SCRATCH_ADR        10'h008

// Word tracker register byte offsets
`define FLL_CTRL_ADR       10'h000
`define FLL_THRESH_ADR     10'h004
`define FLL_MCNT_ADR       10'h008
`define FLL_LCNT_ADR       10'h00C
`define FLL_STAT_ADR       10'h010

// Reserved block byte offsets
`define CUST_PROD_ADR      10'h1F8
`define REVISIONS_ADR      10'h1FC

`define DEVICE_ID          32'hABCD0200
`define REV_LEVEL          32'h00000100
`define SCRATCH_INIT       32'h12345678

`define DEF_REG_VALUE      32'hFABDEFAC   // Undefined fabric or tracker offset
`define RSV_DEF_REG_VALUE  32'hDEFFABAC   // Undefined reserved offset
`define BAD_READ_VALUE     32'hBADFABAC   // No block behind the aperture

`define CUSTOMER_ID        8'h01
`define PRODUCT_ID         8'h00
`define MAJOR_REV          16'h0001
`define MINOR_REV          16'h0000

`define DEF_ACK_TIMEOUT    7

`endif

// ==== src/fpga_ip_pkg.sv ====
package fpga_ip_pkg;

        typedef logic [16:0] wb_addr_t;    // Byte address on the slave bus
        typedef logic [9:0]  reg_addr_t;   // Word offset inside one aperture
        typedef logic [31:0] wb_data_t;
        typedef logic [3:0]  byte_stb_t;

        // Bit-clock edge counts and the tracking threshold
        typedef logic [15:0] word_cnt_t;

        // Default-acknowledge timer
        typedef enum logic [1:0]
        {
                IDLE,
                COUNT,
                ACK
        } def_ack_state_t;

endpackage

// ==== src/fabric_id_regs.sv ====
`timescale 1ns/10ps
`include "fpga_ip_macros.svh"

module fabric_id_regs
(
        input  logic                   wb_clk_i,
        input  logic                   rst_i,
        input  logic                   sel_i,
        input  logic                   stb_i,
        input  logic                   we_i,
        input  fpga_ip_pkg::byte_stb_t byte_stb_i,
        input  fpga_ip_pkg::reg_addr_t adr_i,
        input  fpga_ip_pkg::wb_data_t  dat_i,
        output fpga_ip_pkg::wb_data_t  dat_o,
        output logic                   ack_o,
        output fpga_ip_pkg::wb_data_t  device_id_o
);
        import fpga_ip_pkg::*;

        localparam reg_addr_t ID_WORD      = reg_addr_t'(`ID_ADR >> 2);
        localparam reg_addr_t REV_WORD     = reg_addr_t'(`REV_ADR >> 2);
        localparam reg_addr_t SCRATCH_WORD = reg_addr_t'(`SCRATCH_ADR >> 2);

        wb_data_t scratch;
        logic     scratch_wr;

        // Lands on the same edge that raises ack
        assign scratch_wr = sel_i & stb_i & we_i & ~ack_o & (adr_i == SCRATCH_WORD);

        always_ff @(posedge wb_clk_i)
        begin
                if (rst_i)
                        ack_o <= 1'b0;
                else
                        ack_o <= sel_i & stb_i & ~ack_o;        // Single pulse per access
        end

        always_ff @(posedge wb_clk_i)
        begin
                if (rst_i)
                        scratch <= `SCRATCH_INIT;
                else if (scratch_wr)
                begin
                        for (int i = 0; i < 4; i++)
                        begin
                                if (byte_stb_i[i])
                                        scratch[8*i +: 8] <= dat_i[8*i +: 8];
                        end
                end
        end

        always_comb
        begin
                case (adr_i)
                        ID_WORD:      dat_o = `DEVICE_ID;
                        REV_WORD:     dat_o = `REV_LEVEL;
                        SCRATCH_WORD: dat_o = scratch;
                        default:      dat_o = `DEF_REG_VALUE;
                endcase
        end

        assign device_id_o = `DEVICE_ID;

        // Combinational read data needs the offset held through the ack cycle
        a_adr_held: assert property (@(posedge wb_clk_i) disable iff (rst_i)
                ack_o |-> $stable(adr_i));

endmodule

// ==== src/fll_regs.sv ====
`timescale 1ns/10ps
`include "fpga_ip_macros.svh"

module fll_regs
(
        input  logic                   wb_clk_i,
        input  logic                   rst_i,
        input  logic                   sel_i,
        input  logic                   stb_i,
        input  logic                   we_i,
        input  fpga_ip_pkg::reg_addr_t adr_i,
        input  fpga_ip_pkg::wb_data_t  dat_i,
        input  fpga_ip_pkg::word_cnt_t master_cnt_i,
        input  fpga_ip_pkg::word_cnt_t local_cnt_i,
        input  logic                   speedup_i,
        input  logic                   slowdown_i,
        output fpga_ip_pkg::wb_data_t  dat_o,
        output logic                   ack_o,
        output logic                   enable_o,
        output logic                   clear_o,
        output fpga_ip_pkg::word_cnt_t threshold_o
);
        import fpga_ip_pkg::*;

        localparam reg_addr_t CTRL_WORD   = reg_addr_t'(`FLL_CTRL_ADR >> 2);
        localparam reg_addr_t THRESH_WORD = reg_addr_t'(`FLL_THRESH_ADR >> 2);
        localparam reg_addr_t MCNT_WORD   = reg_addr_t'(`FLL_MCNT_ADR >> 2);
        localparam reg_addr_t LCNT_WORD   = reg_addr_t'(`FLL_LCNT_ADR >> 2);
        localparam reg_addr_t STAT_WORD   = reg_addr_t'(`FLL_STAT_ADR >> 2);

        logic ctrl_wr;
        logic thresh_wr;

        assign ctrl_wr   = sel_i & stb_i & we_i & ~ack_o & (adr_i == CTRL_WORD);
        assign thresh_wr = sel_i & stb_i & we_i & ~ack_o & (adr_i == THRESH_WORD);

        always_ff @(posedge wb_clk_i)
        begin
                if (rst_i)
                begin
                        ack_o       <= 1'b0;
                        enable_o    <= 1'b0;
                        clear_o     <= 1'b0;
                        threshold_o <= '0;
                end
                else
                begin
                        ack_o   <= sel_i & stb_i & ~ack_o;
                        clear_o <= ctrl_wr & dat_i[1];  // Self-clearing
                        if (ctrl_wr)
                                enable_o <= dat_i[0];
                        if (thresh_wr)
                                threshold_o <= dat_i[15:0];
                end
        end

        // Clear bit always reads back as zero
        always_comb
        begin
                case (adr_i)
                        CTRL_WORD:   dat_o = {31'd0, enable_o};
                        THRESH_WORD: dat_o = {16'd0, threshold_o};
                        MCNT_WORD:   dat_o = {16'd0, master_cnt_i};
                        LCNT_WORD:   dat_o = {16'd0, local_cnt_i};
                        STAT_WORD:   dat_o = {30'd0, slowdown_i, speedup_i};
                        default:     dat_o = `DEF_REG_VALUE;
                endcase
        end

endmodule

// ==== src/fll_tracker.sv ====
`timescale 1ns/10ps

module fll_tracker
(
        input  logic                   wb_clk_i,
        input  logic                   rst_i,
        input  logic                   bitclk_master_i,
        input  logic                   bitclk_local_i,
        input  logic                   enable_i,
        input  logic                   clear_i,
        input  fpga_ip_pkg::word_cnt_t threshold_i,
        output fpga_ip_pkg::word_cnt_t master_cnt_o,
        output fpga_ip_pkg::word_cnt_t local_cnt_o,
        output logic                   speedup_o,
        output logic                   slowdown_o,
        output logic                   master_ahead_o,
        output logic                   local_ahead_o
);
        import fpga_ip_pkg::*;

        // Bit 0 master bit clock and bit 1 local bit clock
        logic [1:0] bclk_meta;
        logic [1:0] bclk_sync;
        logic [1:0] bclk_last;
        logic [1:0] bclk_rise;
        word_cnt_t  cnt [2];
        word_cnt_t  master_lead;
        word_cnt_t  local_lead;
        logic       master_gt;
        logic       local_gt;

        always_ff @(posedge wb_clk_i)
        begin
                if (rst_i)
                begin
                        bclk_meta <= '0;
                        bclk_sync <= '0;
                        bclk_last <= '0;
                end
                else
                begin
                        bclk_meta <= {bitclk_local_i, bitclk_master_i};
                        bclk_sync <= bclk_meta;
                        bclk_last <= bclk_sync;         // Edge detect stage
                end
        end

        assign bclk_rise = bclk_sync & ~bclk_last;

        always_ff @(posedge wb_clk_i)
        begin
                for (int i = 0; i < 2; i++)
                begin
                        if (rst_i || clear_i)
                                cnt[i] <= '0;
                        else if (enable_i && bclk_rise[i])
                                cnt[i] <= cnt[i] + 1'b1;
                end
        end

        assign master_cnt_o = cnt[0];
        assign local_cnt_o  = cnt[1];

        assign master_gt   = cnt[0] > cnt[1];
        assign local_gt    = cnt[1] > cnt[0];
        assign master_lead = cnt[0] - cnt[1];
        assign local_lead  = cnt[1] - cnt[0];

        // Flags trail the counters by one cycle
        always_ff @(posedge wb_clk_i)
        begin
                if (rst_i)
                begin
                        master_ahead_o <= 1'b0;
                        local_ahead_o  <= 1'b0;
                        speedup_o      <= 1'b0;
                        slowdown_o     <= 1'b0;
                end
                else
                begin
                        master_ahead_o <= master_gt;
                        local_ahead_o  <= local_gt;
                        speedup_o      <= enable_i && master_gt && (master_lead > threshold_i);
                        slowdown_o     <= enable_i && local_gt && (local_lead > threshold_i);
                end
        end

        // Ahead comparison only holds until a counter wraps
        a_no_wrap: assert property (@(posedge wb_clk_i) disable iff (rst_i || clear_i)
                !(enable_i && ((bclk_rise[0] && cnt[0] == '1) ||
                               (bclk_rise[1] && cnt[1] == '1))));

endmodule

// ==== src/reserved_regs.sv ====
`timescale 1ns/10ps
`include "fpga_ip_macros.svh"

module reserved_regs
(
        input  logic                   wb_clk_i,
        input  logic                   rst_i,
        input  logic                   sel_i,
        input  logic                   cyc_i,
        input  logic                   stb_i,
        input  fpga_ip_pkg::reg_addr_t adr_i,
        input  logic                   bus_ack_i,
        output fpga_ip_pkg::wb_data_t  dat_o,
        output logic                   ack_o
);
        import fpga_ip_pkg::*;

        localparam reg_addr_t  CUST_PROD_WORD = reg_addr_t'(`CUST_PROD_ADR >> 2);
        localparam reg_addr_t  REVISIONS_WORD = reg_addr_t'(`REVISIONS_ADR >> 2);
        localparam logic [2:0] LAST_TICK      = 3'(`DEF_ACK_TIMEOUT - 1);

        logic           reg_ack;
        logic           pending;
        logic [2:0]     tick_cnt;
        def_ack_state_t state;

        // Any access on the bus still waiting for an answer
        assign pending = cyc_i & stb_i & ~bus_ack_i;

        always_ff @(posedge wb_clk_i)
        begin
                if (rst_i)
                        reg_ack <= 1'b0;
                else
                        reg_ack <= sel_i & stb_i & ~reg_ack;
        end

        always_ff @(posedge wb_clk_i)
        begin
                if (rst_i)
                begin
                        state    <= IDLE;
                        tick_cnt <= '0;
                end
                else
                begin
                        case (state)
                                IDLE:
                                begin
                                        tick_cnt <= 3'd1;       // Start edge counts as one
                                        if (pending)
                                                state <= COUNT;
                                end
                                COUNT:
                                begin
                                        tick_cnt <= tick_cnt + 3'd1;
                                        if (!pending)
                                                state <= IDLE;  // Claimed or dropped
                                        else if (tick_cnt == LAST_TICK)
                                                state <= ACK;
                                end
                                default:
                                        state <= IDLE;          // Ack for one cycle only
                        endcase
                end
        end

        assign ack_o = reg_ack | (state == ACK);

        always_comb
        begin
                case (adr_i)
                        CUST_PROD_WORD: dat_o = {16'd0, `CUSTOMER_ID, `PRODUCT_ID};
                        REVISIONS_WORD: dat_o = {`MAJOR_REV, `MINOR_REV};
                        default:        dat_o = `RSV_DEF_REG_VALUE;
                endcase
        end

endmodule

// ==== src/fpga_ip_top.sv ====
`timescale 1ns/10ps
`include "fpga_ip_macros.svh"

module fpga_ip_top
(
        input  logic                   wb_clk_i,
        input  logic                   rst_i,
        input  fpga_ip_pkg::wb_addr_t  wbs_adr_i,
        input  logic                   wbs_cyc_i,
        input  fpga_ip_pkg::byte_stb_t wbs_byte_stb_i,
        input  logic                   wbs_we_i,
        input  logic                   wbs_stb_i,
        input  fpga_ip_pkg::wb_data_t  wbs_wr_dat_i,
        input  logic                   bitclk_master_i,
        input  logic                   bitclk_local_i,
        output fpga_ip_pkg::wb_data_t  wbs_rd_dat_o,
        output logic                   wbs_ack_o,
        output fpga_ip_pkg::wb_data_t  device_id_o,
        output logic                   interrupt_speedup_o,
        output logic                   interrupt_slowdown_o,
        output logic                   master_wordcnt_is_ahead_o,
        output logic                   local_wordcnt_is_ahead_o
);
        import fpga_ip_pkg::*;

        localparam int APER_W = `APER_MSB - `APER_LSB + 1;
        localparam logic [APER_W-1:0] FAB_APER = APER_W'(`FPGA_REG_BASE >> `APER_LSB);
        localparam logic [APER_W-1:0] FLL_APER = APER_W'(`FLL_BASE >> `APER_LSB);
        localparam logic [APER_W-1:0] RSV_APER = APER_W'(`RESERVED_BASE >> `APER_LSB);

        logic [APER_W-1:0] aper;
        reg_addr_t         word_adr;
        logic              sel_fab;
        logic              sel_fll;
        logic              sel_rsv;
        logic              ack_fab;
        logic              ack_fll;
        logic              ack_rsv;
        wb_data_t          dat_fab;
        wb_data_t          dat_fll;
        wb_data_t          dat_rsv;
        logic              fll_enable;
        logic              fll_clear;
        word_cnt_t         fll_threshold;
        word_cnt_t         master_cnt;
        word_cnt_t         local_cnt;

        assign aper     = wbs_adr_i[`APER_MSB:`APER_LSB];
        assign word_adr = wbs_adr_i[`APER_LSB-1:2];     // Blocks decode word offsets

        assign sel_fab = wbs_cyc_i & (aper == FAB_APER);
        assign sel_fll = wbs_cyc_i & (aper == FLL_APER);
        assign sel_rsv = wbs_cyc_i & (aper == RSV_APER);

        // Timer ack arrives through the reserved block
        assign wbs_ack_o = ack_fab | ack_fll | ack_rsv;

        always_comb
        begin
                case (aper)
                        FAB_APER: wbs_rd_dat_o = dat_fab;
                        FLL_APER: wbs_rd_dat_o = dat_fll;
                        RSV_APER: wbs_rd_dat_o = dat_rsv;
                        default:  wbs_rd_dat_o = `BAD_READ_VALUE;
                endcase
        end

        fabric_id_regs u_fabric_id_regs
        (
                .wb_clk_i    (wb_clk_i),
                .rst_i       (rst_i),
                .sel_i       (sel_fab),
                .stb_i       (wbs_stb_i),
                .we_i        (wbs_we_i),
                .byte_stb_i  (wbs_byte_stb_i),
                .adr_i       (word_adr),
                .dat_i       (wbs_wr_dat_i),
                .dat_o       (dat_fab),
                .ack_o       (ack_fab),
                .device_id_o (device_id_o)
        );

        fll_regs u_fll_regs
        (
                .wb_clk_i     (wb_clk_i),
                .rst_i        (rst_i),
                .sel_i        (sel_fll),
                .stb_i        (wbs_stb_i),
                .we_i         (wbs_we_i),
                .adr_i        (word_adr),
                .dat_i        (wbs_wr_dat_i),
                .master_cnt_i (master_cnt),
                .local_cnt_i  (local_cnt),
                .speedup_i    (interrupt_speedup_o),
                .slowdown_i   (interrupt_slowdown_o),
                .dat_o        (dat_fll),
                .ack_o        (ack_fll),
                .enable_o     (fll_enable),
                .clear_o      (fll_clear),
                .threshold_o  (fll_threshold)
        );

        fll_tracker u_fll_tracker
        (
                .wb_clk_i        (wb_clk_i),
                .rst_i           (rst_i),
                .bitclk_master_i (bitclk_master_i),
                .bitclk_local_i  (bitclk_local_i),
                .enable_i        (fll_enable),
                .clear_i         (fll_clear),
                .threshold_i     (fll_threshold),
                .master_cnt_o    (master_cnt),
                .local_cnt_o     (local_cnt),
                .speedup_o       (interrupt_speedup_o),
                .slowdown_o      (interrupt_slowdown_o),
                .master_ahead_o  (master_wordcnt_is_ahead_o),
                .local_ahead_o   (local_wordcnt_is_ahead_o)
        );

        reserved_regs u_reserved_regs
        (
                .wb_clk_i  (wb_clk_i),
                .rst_i     (rst_i),
                .sel_i     (sel_rsv),
                .cyc_i     (wbs_cyc_i),
                .stb_i     (wbs_stb_i),
                .adr_i     (word_adr),
                .bus_ack_i (wbs_ack_o),
                .dat_o     (dat_rsv),
                .ack_o     (ack_rsv)
        );

        // Every block and the timer answer only inside a bus cycle
        a_ack_in_cycle: assert property (@(posedge wb_clk_i) disable iff (rst_i)
                wbs_ack_o |-> wbs_cyc_i);

endmodule

// ==== bench/tb_fpga_ip.sv ====
`timescale 1ns/10ps
`include "fpga_ip_macros.svh"

module tb_fpga_ip;
        import fpga_ip_pkg::*;

        localparam int ACK_TIMEOUT = 20;        // Clock cycles before giving up on ack

        logic      wb_clk_i;
        logic      rst_i;
        wb_addr_t  wbs_adr_i;
        logic      wbs_cyc_i;
        byte_stb_t wbs_byte_stb_i;
        logic      wbs_we_i;
        logic      wbs_stb_i;
        wb_data_t  wbs_wr_dat_i;
        logic      bitclk_master_i;
        logic      bitclk_local_i;
        wb_data_t  wbs_rd_dat_o;
        logic      wbs_ack_o;
        wb_data_t  device_id_o;
        logic      interrupt_speedup_o;
        logic      interrupt_slowdown_o;
        logic      master_wordcnt_is_ahead_o;
        logic      local_wordcnt_is_ahead_o;

        int        error_count;
        int        check_count;
        wb_data_t  mdl_scratch;
        word_cnt_t mdl_mcnt;            // Rising edges seen while enabled
        word_cnt_t mdl_lcnt;
        word_cnt_t mdl_thresh;
        logic      mdl_enable;

        fpga_ip_top uut (.*);

        initial
        begin
                wb_clk_i = 1'b0;
                forever
                        #20 wb_clk_i = ~wb_clk_i;
        end

        function automatic int unsigned rand_below(input int unsigned n);
                return $urandom % n;
        endfunction

        function automatic wb_addr_t word_addr(input wb_addr_t base, input int unsigned word);
                return base + wb_addr_t'(word * 4);
        endfunction

        task automatic check_value(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
                check_count++;
                if (got !== exp)
                begin
                        $display("MISMATCH %s: got 0x%08h, expected 0x%08h", name, got, exp);
                        error_count++;
                end
        endtask

        // Called and returns on a falling edge
        task automatic bus_access(input wb_addr_t adr, input logic we, input wb_data_t dat,
                                  input byte_stb_t be, input logic mapped,
                                  output wb_data_t rdat);
                int waited;
                waited         = 0;
                wbs_adr_i      = adr;
                wbs_we_i       = we;
                wbs_wr_dat_i   = dat;
                wbs_byte_stb_i = be;
                wbs_cyc_i      = 1'b1;
                wbs_stb_i      = 1'b1;
                @(negedge wb_clk_i);
                while (!wbs_ack_o && waited < ACK_TIMEOUT)
                begin
                        @(negedge wb_clk_i);
                        waited++;
                end
                if (!wbs_ack_o)
                begin
                        $display("No acknowledge within %0d cycles for address 0x%05h",
                                 ACK_TIMEOUT, adr);
                        error_count++;
                end
                else if (mapped)
                        check_value("ack latency", 32'(waited), 32'd0);
                rdat = wbs_rd_dat_o;
                @(negedge wb_clk_i);            // Strobe still held across the ack edge
                check_value("wbs_ack_o", {31'd0, wbs_ack_o}, 32'd0);    // No second ack
                wbs_cyc_i = 1'b0;
                wbs_stb_i = 1'b0;
                wbs_we_i  = 1'b0;
        endtask

        task automatic bus_write(input wb_addr_t adr, input wb_data_t dat, input byte_stb_t be);
                wb_data_t unused;
                bus_access(adr, 1'b1, dat, be, 1'b1, unused);
        endtask

        task automatic read_expect(input string name, input wb_addr_t adr, input logic mapped,
                                   input wb_data_t exp);
                wb_data_t rdat;
                bus_access(adr, 1'b0, '0, 4'hF, mapped, rdat);
                check_value({"wbs_rd_dat_o ", name}, rdat, exp);
        endtask

        // Each level held at least 4 clocks and 6 quiet clocks at the end
        task automatic run_bitclocks(input int unsigned cycles, input int unsigned m_span,
                                     input int unsigned l_span);
                int unsigned m_hold;
                int unsigned l_hold;
                m_hold = 4 + rand_below(m_span);
                l_hold = 4 + rand_below(l_span);
                repeat (cycles)
                begin
                        @(negedge wb_clk_i);
                        m_hold--;
                        l_hold--;
                        if (m_hold == 0)
                        begin
                                bitclk_master_i = ~bitclk_master_i;
                                if (bitclk_master_i && mdl_enable)
                                        mdl_mcnt++;
                                m_hold = 4 + rand_below(m_span);
                        end
                        if (l_hold == 0)
                        begin
                                bitclk_local_i = ~bitclk_local_i;
                                if (bitclk_local_i && mdl_enable)
                                        mdl_lcnt++;
                                l_hold = 4 + rand_below(l_span);
                        end
                end
                repeat (6)
                        @(negedge wb_clk_i);
        endtask

        task automatic check_tracker();
                word_cnt_t lead_m;
                word_cnt_t lead_l;
                logic      exp_up;
                logic      exp_down;
                lead_m   = mdl_mcnt - mdl_lcnt;
                lead_l   = mdl_lcnt - mdl_mcnt;
                exp_up   = mdl_enable && (mdl_mcnt > mdl_lcnt) && (lead_m > mdl_thresh);
                exp_down = mdl_enable && (mdl_lcnt > mdl_mcnt) && (lead_l > mdl_thresh);
                read_expect("master count", word_addr(`FLL_BASE, `FLL_MCNT_ADR / 4), 1'b1,
                            {16'd0, mdl_mcnt});
                read_expect("local count", word_addr(`FLL_BASE, `FLL_LCNT_ADR / 4), 1'b1,
                            {16'd0, mdl_lcnt});
                check_value("interrupt_speedup_o", {31'd0, interrupt_speedup_o}, {31'd0, exp_up});
                check_value("interrupt_slowdown_o", {31'd0, interrupt_slowdown_o},
                            {31'd0, exp_down});
                check_value("master_wordcnt_is_ahead_o", {31'd0, master_wordcnt_is_ahead_o},
                            {31'd0, mdl_mcnt > mdl_lcnt});
                check_value("local_wordcnt_is_ahead_o", {31'd0, local_wordcnt_is_ahead_o},
                            {31'd0, mdl_lcnt > mdl_mcnt});
                read_expect("status", word_addr(`FLL_BASE, `FLL_STAT_ADR / 4), 1'b1,
                            {30'd0, exp_down, exp_up});
        endtask

        initial
        begin
                wb_data_t    wr;
                byte_stb_t   be;
                int unsigned word;
                error_count     = 0;
                check_count     = 0;
                rst_i           = 1'b1;
                wbs_adr_i       = '0;
                wbs_cyc_i       = 1'b0;
                wbs_byte_stb_i  = '0;
                wbs_we_i        = 1'b0;
                wbs_stb_i       = 1'b0;
                wbs_wr_dat_i    = '0;
                bitclk_master_i = 1'b0;
                bitclk_local_i  = 1'b0;
                mdl_scratch     = `SCRATCH_INIT;
                mdl_mcnt        = '0;
                mdl_lcnt        = '0;
                mdl_thresh      = '0;
                mdl_enable      = 1'b0;
                word            = $urandom(32'hcf02_5221);      // Seeds the generator
                repeat (3)
                        @(posedge wb_clk_i);
                @(negedge wb_clk_i);
                rst_i = 1'b0;

                check_value("wbs_ack_o", {31'd0, wbs_ack_o}, 32'd0);
                check_value("interrupt_speedup_o", {31'd0, interrupt_speedup_o}, 32'd0);
                check_value("interrupt_slowdown_o", {31'd0, interrupt_slowdown_o}, 32'd0);
                check_value("device_id_o", device_id_o, `DEVICE_ID);
                read_expect("ID", word_addr(`FPGA_REG_BASE, `ID_ADR / 4), 1'b1, `DEVICE_ID);
                read_expect("revision", word_addr(`FPGA_REG_BASE, `REV_ADR / 4), 1'b1, `REV_LEVEL);
                read_expect("customer/product", word_addr(`RESERVED_BASE, `CUST_PROD_ADR / 4),
                            1'b1, {16'd0, `CUSTOMER_ID, `PRODUCT_ID});
                read_expect("revisions", word_addr(`RESERVED_BASE, `REVISIONS_ADR / 4), 1'b1,
                            {`MAJOR_REV, `MINOR_REV});
                check_tracker();

                // Scratch with byte-merged writes
                repeat (16)
                begin
                        wr = $urandom;
                        be = byte_stb_t'(rand_below(16));
                        bus_write(word_addr(`FPGA_REG_BASE, `SCRATCH_ADR / 4), wr, be);
                        for (int i = 0; i < 4; i++)
                        begin
                                if (be[i])
                                        mdl_scratch[8*i +: 8] = wr[8*i +: 8];
                        end
                        read_expect("scratch", word_addr(`FPGA_REG_BASE, `SCRATCH_ADR / 4), 1'b1,
                                    mdl_scratch);
                end

                repeat (8)
                begin
                        read_expect("fabric undefined", word_addr(`FPGA_REG_BASE,
                                    3 + rand_below(1021)), 1'b1, `DEF_REG_VALUE);
                        read_expect("tracker undefined", word_addr(`FLL_BASE,
                                    5 + rand_below(1019)), 1'b1, `DEF_REG_VALUE);
                        word = rand_below(1024);
                        if (word == 126 || word == 127)         // Skip the two defined words
                                word = word - 2;
                        read_expect("reserved undefined", word_addr(`RESERVED_BASE, word), 1'b1,
                                    `RSV_DEF_REG_VALUE);
                        word = rand_below(29);
                        word = (word < 3) ? word + 2 : word + 3;        // Apertures 2 to 4 and 6 to 31
                        read_expect("unmapped", wb_addr_t'((word << 12) | rand_below(4096)), 1'b0,
                                    `BAD_READ_VALUE);
                end

                mdl_enable = 1'b1;
                bus_write(word_addr(`FLL_BASE, `FLL_CTRL_ADR / 4), 32'h1, 4'hF);
                for (int r = 0; r < 6; r++)
                begin
                        mdl_thresh = word_cnt_t'(rand_below(6));
                        bus_write(word_addr(`FLL_BASE, `FLL_THRESH_ADR / 4),
                                  {16'(rand_below(65536)), mdl_thresh}, 4'hF);
                        read_expect("threshold", word_addr(`FLL_BASE, `FLL_THRESH_ADR / 4), 1'b1,
                                    {16'd0, mdl_thresh});
                        run_bitclocks(40 + rand_below(120), 1 + rand_below(8), 1 + rand_below(8));
                        check_tracker();
                        if (r == 2)
                        begin
                                bus_write(word_addr(`FLL_BASE, `FLL_CTRL_ADR / 4), 32'h3, 4'hF);
                                mdl_mcnt = '0;
                                mdl_lcnt = '0;
                                read_expect("control", word_addr(`FLL_BASE, `FLL_CTRL_ADR / 4),
                                            1'b1, 32'h1);
                                check_tracker();
                        end
                end

                // Fast master from zero and then the tracker switched off
                bus_write(word_addr(`FLL_BASE, `FLL_CTRL_ADR / 4), 32'h3, 4'hF);
                mdl_mcnt   = '0;
                mdl_lcnt   = '0;
                mdl_thresh = '0;
                bus_write(word_addr(`FLL_BASE, `FLL_THRESH_ADR / 4), 32'h0, 4'hF);
                run_bitclocks(200, 1, 12);
                check_tracker();
                mdl_enable = 1'b0;
                bus_write(word_addr(`FLL_BASE, `FLL_CTRL_ADR / 4), 32'h0, 4'hF);
                check_tracker();

                $display("Checks: %0d, errors: %0d", check_count, error_count);
                if (error_count == 0)
                        $display("ALL TESTS PASSED");
                else
                        $display("SOME TESTS FAILED");
                $finish;
        end

endmodule

// ==== sources.f ====
+incdir+include
src/fpga_ip_pkg.sv
src/fabric_id_regs.sv
src/fll_regs.sv
src/fll_tracker.sv
src/reserved_regs.sv
src/fpga_ip_top.sv
bench/tb_fpga_ip.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_fpga_ip
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps
PASS_MSG  ?= ALL TESTS PASSED

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard include/*.svh)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES) $(HEADERS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# The log decides pass or fail
run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
